//--- build.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/l1_cache.sv
hdl/memory_arbiter.sv
hdl/caches_top.sv
tb/tb_mem_model.sv
tb/tb_caches_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cache front end testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
  echo "verilator not found"
  exit 1
fi

if ! verilator --binary -f build.f --top-module tb_caches_top -o tb_sim; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
echo "pass message not found"
exit 1

//--- tb/tb_caches_top.sv
// testbench top for the cache front end that runs a stimulus table against a shadow memory
`include "cache_defines.svh"
`default_nettype none

module tb_caches_top;

  localparam logic PORT_I = 1'b0;
  localparam logic PORT_D = 1'b1;
  localparam int OP_RD = 0, OP_WR = 1, OP_CLR = 2, OP_DUAL = 3;
  localparam int TIMEOUT = 200;  // cycles per wait

  typedef struct {
    logic        port;
    int          op;
    logic        rnd;        // random MMIO address instead of addr
    logic [31:0] addr;       // icache address for dual reads
    logic [31:0] wdata;      // dcache address for dual reads
    int          exp_reads;  // memory reads caused by the row
  } row_t;

  logic CLK, i_rst, i_iclear, i_dclear, o_iclear_done, o_dclear_done;
  cache_pkg::bus_req_t i_icpu_req, i_dcpu_req, o_mem_req;
  cache_pkg::bus_rsp_t o_icpu_rsp, o_dcpu_rsp, i_mem_rsp;
  int mem_reads, mem_writes, errors;
  row_t rows[$];
  logic [31:0] shadow [logic [31:0]];

  caches_top i_dut (
    .CLK(CLK), .i_rst(i_rst),
    .i_iclear(i_iclear), .i_dclear(i_dclear),
    .o_iclear_done(o_iclear_done), .o_dclear_done(o_dclear_done),
    .i_icpu_req(i_icpu_req), .o_icpu_rsp(o_icpu_rsp),
    .i_dcpu_req(i_dcpu_req), .o_dcpu_rsp(o_dcpu_rsp),
    .o_mem_req(o_mem_req), .i_mem_rsp(i_mem_rsp)
  );

  tb_mem_model u_mem (
    .CLK(CLK), .i_rst(i_rst), .i_req(o_mem_req), .o_rsp(i_mem_rsp),
    .o_reads(mem_reads), .o_writes(mem_writes)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // expected word from the shadow or the address mix of unwritten memory
  function automatic logic [31:0] shadow_read(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    if (shadow.exists(w)) return shadow[w];
    return w ^ 32'ha5c3_0f96 ^ {w[7:0], w[31:8]};
  endfunction

  function automatic cache_pkg::bus_req_t make_req(input logic [31:0] a, input logic [31:0] d,
                                                    input logic rd, input logic wr);
    cache_pkg::bus_req_t r;
    r.addr  = a;
    r.wdata = d;
    r.ren   = rd;
    r.wen   = wr;
    return r;
  endfunction

  task automatic stop_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rsp(input cache_pkg::bus_rsp_t rsp, input logic [31:0] exp,
                           input string what);
    if (rsp.busy !== 1'b0 || rsp.rdata !== exp) begin
      stop_run($sformatf("error at %0t: %s read %h, expected %h", $time, what, rsp.rdata, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      stop_run($sformatf("error at %0t: %s rose by %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_done(input logic seen, input string what);
    if (!seen) stop_run($sformatf("the %s clear never signaled done", what));
  endtask

  task automatic drive_port(input logic port, input cache_pkg::bus_req_t r);
    if (port == PORT_I) i_icpu_req = r;
    else i_dcpu_req = r;
  endtask

  // one access held until busy drops and released the cycle after
  task automatic cpu_access(input logic port, input cache_pkg::bus_req_t r,
                            output cache_pkg::bus_rsp_t rsp);
    int waited;
    waited = 0;
    @(negedge CLK);
    drive_port(port, r);
    do begin
      @(negedge CLK);
      rsp = (port == PORT_I) ? o_icpu_rsp : o_dcpu_rsp;
      waited++;
      if (waited > TIMEOUT) stop_run("timeout waiting for a cpu response");
    end while (rsp.busy);
    @(negedge CLK);
    drive_port(port, '0);
  endtask

  task automatic dual_read(input logic [31:0] ia, input logic [31:0] da,
                           output cache_pkg::bus_rsp_t irsp, output cache_pkg::bus_rsp_t drsp);
    cache_pkg::bus_rsp_t isnap, dsnap;
    logic idone, ddone;
    int waited;
    idone = 1'b0;
    ddone = 1'b0;
    waited = 0;
    @(negedge CLK);
    i_icpu_req = make_req(ia, '0, 1'b1, 1'b0);
    i_dcpu_req = make_req(da, '0, 1'b1, 1'b0);
    while (!(idone && ddone)) begin
      @(negedge CLK);
      isnap = o_icpu_rsp;  // sample before any drive
      dsnap = o_dcpu_rsp;
      if (idone) i_icpu_req = '0;
      if (ddone) i_dcpu_req = '0;
      if (!idone && !isnap.busy) begin
        idone = 1'b1;
        irsp  = isnap;
      end
      if (!ddone && !dsnap.busy) begin
        ddone = 1'b1;
        drsp  = dsnap;
      end
      waited++;
      if (waited > TIMEOUT) stop_run("timeout waiting for the dual read");
    end
    @(negedge CLK);
    i_icpu_req = '0;
    i_dcpu_req = '0;
  endtask

  task automatic clear_cache(input logic port, output logic seen);
    int waited;
    seen = 1'b0;
    @(negedge CLK);
    if (port == PORT_I) i_iclear = 1'b1;
    else i_dclear = 1'b1;
    @(negedge CLK);
    i_iclear = 1'b0;  // one cycle pulse
    i_dclear = 1'b0;
    for (waited = 0; waited < TIMEOUT && !seen; waited++) begin
      @(negedge CLK);
      seen = (port == PORT_I) ? o_iclear_done : o_dclear_done;
    end
  endtask

  task automatic add_row(input logic port, input int op, input logic rnd, input logic [31:0] a,
                         input logic [31:0] d, input int exp);
    row_t r;
    r.port = port;
    r.op = op;
    r.rnd = rnd;
    r.addr = a;
    r.wdata = d;
    r.exp_reads = exp;
    rows.push_back(r);
  endtask

  initial begin
    cache_pkg::bus_rsp_t rsp, drsp;
    logic [31:0] a;
    logic seen;
    int r0, w0, exp_w;
    errors = 0;
    void'($urandom(93514));
    i_rst = 1'b1;
    i_iclear = 1'b0;
    i_dclear = 1'b0;
    i_icpu_req = '0;
    i_dcpu_req = '0;
    add_row(PORT_I, OP_RD, 1'b0, 32'h100, 0, 1);  // miss then hit
    add_row(PORT_I, OP_RD, 1'b0, 32'h100, 0, 0);
    add_row(PORT_D, OP_RD, 1'b0, 32'h200, 0, 1);
    add_row(PORT_D, OP_RD, 1'b0, 32'h200, 0, 0);
    add_row(PORT_D, OP_WR, 1'b0, 32'h200, 32'hdead_beef, 0);  // write hit
    add_row(PORT_D, OP_RD, 1'b0, 32'h200, 0, 0);
    add_row(PORT_I, OP_RD, 1'b0, 32'h200, 0, 1);  // other port sees it
    add_row(PORT_D, OP_WR, 1'b0, 32'h300, 32'h1234_5678, 0);  // no allocate
    add_row(PORT_D, OP_RD, 1'b0, 32'h300, 0, 1);
    add_row(PORT_D, OP_RD, 1'b0, `NONCACHE_START_ADDR + 32'h10, 0, 1);
    add_row(PORT_D, OP_RD, 1'b0, `NONCACHE_START_ADDR + 32'h10, 0, 1);
    add_row(PORT_I, OP_RD, 1'b0, `NONCACHE_START_ADDR + 32'h20, 0, 1);
    add_row(PORT_D, OP_WR, 1'b0, `NONCACHE_START_ADDR + 32'h10, 32'h0000_cafe, 0);
    add_row(PORT_D, OP_RD, 1'b0, `NONCACHE_START_ADDR + 32'h10, 0, 1);
    add_row(PORT_I, OP_CLR, 1'b0, 0, 0, 0);
    add_row(PORT_I, OP_RD, 1'b0, 32'h200, 0, 1);  // line was valid before the clear
    add_row(PORT_D, OP_CLR, 1'b0, 0, 0, 0);
    add_row(PORT_D, OP_RD, 1'b0, 32'h300, 0, 1);  // line was valid before the clear
    add_row(PORT_I, OP_DUAL, 1'b0, 32'h440, 32'h540, 2);  // both miss
    repeat (4) add_row(PORT_D, OP_RD, 1'b1, 0, 0, 1);
    repeat (2) add_row(PORT_I, OP_RD, 1'b1, 0, 0, 1);
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    i_rst = 1'b0;
    foreach (rows[i]) begin
      r0 = mem_reads;
      w0 = mem_writes;
      exp_w = 0;
      a = rows[i].rnd ? (`NONCACHE_START_ADDR | ($urandom & 32'h0fff_fffc)) : rows[i].addr;
      case (rows[i].op)
        OP_RD: begin
          cpu_access(rows[i].port, make_req(a, '0, 1'b1, 1'b0), rsp);
          check_rsp(rsp, shadow_read(a), $sformatf("row %0d", i));
        end
        OP_WR: begin
          cpu_access(rows[i].port, make_req(a, rows[i].wdata, 1'b0, 1'b1), rsp);
          shadow[{a[31:2], 2'b00}] = rows[i].wdata;
          exp_w = 1;
        end
        OP_CLR: begin
          clear_cache(rows[i].port, seen);
          check_done(seen, rows[i].port == PORT_I ? "icache" : "dcache");
        end
        default: begin
          dual_read(a, rows[i].wdata, rsp, drsp);
          check_rsp(rsp, shadow_read(a), $sformatf("row %0d icache", i));
          check_rsp(drsp, shadow_read(rows[i].wdata), $sformatf("row %0d dcache", i));
        end
      endcase
      check_count(mem_reads - r0, rows[i].exp_reads, $sformatf("row %0d memory reads", i));
      check_count(mem_writes - w0, exp_w, $sformatf("row %0d memory writes", i));
    end
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_mem_model.sv
// behavioral word memory for the testbench, serves the cache top memory port with fixed latency
`include "cache_defines.svh"
`default_nettype none

module tb_mem_model (
  input  wire logic                CLK,
  input  wire logic                i_rst,
  input  wire cache_pkg::bus_req_t i_req,
  output cache_pkg::bus_rsp_t      o_rsp,
  output int                       o_reads,   // completed reads
  output int                       o_writes   // completed writes
);

  logic [`DATA_W-1:0] mem [logic [`DATA_W-1:0]];  // sparse, only written words
  int                 cnt;                         // busy cycles spent on this access
  logic               req_on;
  logic [`DATA_W-1:0] word_addr;

  // unwritten words read as a mix of the whole address
  function automatic logic [`DATA_W-1:0] fill_word(input logic [`DATA_W-1:0] a);
    return a ^ 32'ha5c3_0f96 ^ {a[7:0], a[31:8]};
  endfunction

  function automatic logic [`DATA_W-1:0] read_word(input logic [`DATA_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  assign req_on    = i_req.ren | i_req.wen;
  assign word_addr = {i_req.addr[`DATA_W-1:2], 2'b00};

  assign o_rsp.busy  = req_on && (cnt != `MEM_LATENCY);
  assign o_rsp.rdata = read_word(word_addr);

  always @(posedge CLK) begin
    if (i_rst) begin
      cnt      <= 0;
      o_reads  <= 0;
      o_writes <= 0;
    end else if (req_on) begin
      if (cnt == `MEM_LATENCY) begin
        cnt <= 0;  // completing cycle
        if (i_req.wen) begin
          mem[word_addr] = i_req.wdata;
          o_writes <= o_writes + 1;
        end else begin
          o_reads <= o_reads + 1;
        end
      end else begin
        cnt <= cnt + 1;
      end
    end else begin
      cnt <= 0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/caches_top.sv
// cache front end top, instruction and data L1s sharing one memory port through the arbiter
`include "cache_defines.svh"
`default_nettype none

module caches_top (
  input  wire logic                CLK,
  input  wire logic                i_rst,
  input  wire logic                i_iclear,       // icache invalidate pulse
  input  wire logic                i_dclear,       // dcache invalidate pulse
  output logic                     o_iclear_done,
  output logic                     o_dclear_done,
  input  wire cache_pkg::bus_req_t i_icpu_req,     // instruction fetch port
  output cache_pkg::bus_rsp_t      o_icpu_rsp,
  input  wire cache_pkg::bus_req_t i_dcpu_req,     // load/store port
  output cache_pkg::bus_rsp_t      o_dcpu_rsp,
  output cache_pkg::bus_req_t      o_mem_req,      // to the memory bus
  input  wire cache_pkg::bus_rsp_t i_mem_rsp
);

  localparam int ICACHE_LINES = `L1_LINES;
  localparam int DCACHE_LINES = 8;  // smaller data side

  // cache miss links into the arbiter
  cache_pkg::bus_req_t icache_mem_req;
  cache_pkg::bus_req_t dcache_mem_req;
  cache_pkg::bus_rsp_t icache_mem_rsp;
  cache_pkg::bus_rsp_t dcache_mem_rsp;

  l1_cache #(
    .LINES(ICACHE_LINES)
  ) u_icache (
    .CLK          (CLK),
    .i_rst        (i_rst),
    .i_clear      (i_iclear),
    .o_clear_done (o_iclear_done),
    .i_cpu_req    (i_icpu_req),
    .o_cpu_rsp    (o_icpu_rsp),
    .o_mem_req    (icache_mem_req),
    .i_mem_rsp    (icache_mem_rsp)
  );

  l1_cache #(
    .LINES(DCACHE_LINES)
  ) u_dcache (
    .CLK          (CLK),
    .i_rst        (i_rst),
    .i_clear      (i_dclear),
    .o_clear_done (o_dclear_done),
    .i_cpu_req    (i_dcpu_req),
    .o_cpu_rsp    (o_dcpu_rsp),
    .o_mem_req    (dcache_mem_req),
    .i_mem_rsp    (dcache_mem_rsp)
  );

  memory_arbiter u_mem_arb (
    .CLK          (CLK),
    .i_rst        (i_rst),
    .i_icache_req (icache_mem_req),
    .i_dcache_req (dcache_mem_req),
    .o_icache_rsp (icache_mem_rsp),
    .o_dcache_rsp (dcache_mem_rsp),
    .o_mem_req    (o_mem_req),
    .i_mem_rsp    (i_mem_rsp)
  );

endmodule

`default_nettype wire

//--- hdl/memory_arbiter.sv
// fixed-priority arbiter putting the icache and dcache miss traffic on one memory bus
`default_nettype none

module memory_arbiter (
  input  wire logic                CLK,
  input  wire logic                i_rst,
  input  wire cache_pkg::bus_req_t i_icache_req,
  input  wire cache_pkg::bus_req_t i_dcache_req,
  output cache_pkg::bus_rsp_t      o_icache_rsp,
  output cache_pkg::bus_rsp_t      o_dcache_rsp,
  output cache_pkg::bus_req_t      o_mem_req,
  input  wire cache_pkg::bus_rsp_t i_mem_rsp
);

  typedef enum logic [1:0] {
    ARB_IDLE,    // bus free, pick this cycle
    ARB_ICACHE,  // instruction side owns the bus
    ARB_DCACHE   // data side owns the bus
  } owner_t;

  owner_t owner_q;  // registered grant
  owner_t owner;    // grant in effect this cycle

  logic ireq;
  logic dreq;
  logic mem_req_on;
  logic xfer_done;

  assign ireq = i_icache_req.ren | i_icache_req.wen;
  assign dreq = i_dcache_req.ren | i_dcache_req.wen;

  // new grant only on an idle bus, data before instructions
  always_comb begin
    owner = owner_q;
    if (owner_q == ARB_IDLE) begin
      if (dreq) begin
        owner = ARB_DCACHE;
      end else if (ireq) begin
        owner = ARB_ICACHE;
      end
    end
  end

  // owner's request passes straight through, no added cycle
  always_comb begin
    case (owner)
      ARB_DCACHE: o_mem_req = i_dcache_req;
      ARB_ICACHE: o_mem_req = i_icache_req;
      default:    o_mem_req = '0;
    endcase
  end

  assign mem_req_on = o_mem_req.ren | o_mem_req.wen;
  assign xfer_done  = mem_req_on & ~i_mem_rsp.busy;

  // grant kept across the transfer, released on its last cycle
  always_ff @(posedge CLK) begin
    if (i_rst) begin
      owner_q <= ARB_IDLE;
    end else if (xfer_done || !mem_req_on) begin
      owner_q <= ARB_IDLE;
    end else begin
      owner_q <= owner;
    end
  end

  // owner follows memory busy, the loser just sees its own request as busy
  always_comb begin
    o_icache_rsp.rdata = i_mem_rsp.rdata;  // only sampled by the owner
    o_dcache_rsp.rdata = i_mem_rsp.rdata;
    o_icache_rsp.busy  = ireq;             // back-pressure while waiting
    o_dcache_rsp.busy  = dreq;
    if (owner == ARB_ICACHE) begin
      o_icache_rsp.busy = i_mem_rsp.busy;
    end
    if (owner == ARB_DCACHE) begin
      o_dcache_rsp.busy = i_mem_rsp.busy;
    end
  end

endmodule

`default_nettype wire

//--- hdl/l1_cache.sv
// direct-mapped write-through L1 with MMIO bypass and line clear, one per cpu port
`include "cache_defines.svh"
`default_nettype none

module l1_cache #(
  parameter int LINES = `L1_LINES  // power of two
) (
  input  wire logic                CLK,
  input  wire logic                i_rst,
  input  wire logic                i_clear,       // one cycle pulse
  output logic                     o_clear_done,  // one cycle pulse
  input  wire cache_pkg::bus_req_t i_cpu_req,
  output cache_pkg::bus_rsp_t      o_cpu_rsp,
  output cache_pkg::bus_req_t      o_mem_req,
  input  wire cache_pkg::bus_rsp_t i_mem_rsp
);

  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = `DATA_W - IDX_W - 2;  // above index and byte offset

  typedef enum logic [2:0] {
    ST_IDLE,    // waiting for a request or a clear
    ST_LOOKUP,  // tag compare on the held request
    ST_MEM,     // request forwarded to memory
    ST_RESP,    // memory done, answer the cpu
    ST_CLEAR    // invalidating one line per cycle
  } state_t;

  state_t state_q, state_n;

  // line storage
  logic [TAG_W-1:0]   tag_arr  [LINES];
  logic [`DATA_W-1:0] data_arr [LINES];
  logic [LINES-1:0]   valid_q;          // the only part under reset

  logic [IDX_W-1:0]   clr_idx;          // walks all lines during a clear
  logic               clear_pend;       // clear seen while an access was running
  logic [`DATA_W-1:0] rdata_q;          // memory read data, replayed in ST_RESP

  logic [IDX_W-1:0]   idx;
  logic [TAG_W-1:0]   tag;
  logic               req_on;
  logic               rd_op;
  logic               wr_op;
  logic               cacheable;
  logic               hit;
  logic               rd_hit;
  logic               start_clear;
  logic               mem_done;
  logic               fill;
  logic               wr_update;
  logic               last_line;

  // address split, word aligned
  assign idx = i_cpu_req.addr[IDX_W+1:2];
  assign tag = i_cpu_req.addr[`DATA_W-1:IDX_W+2];

  assign req_on    = i_cpu_req.ren | i_cpu_req.wen;
  assign wr_op     = i_cpu_req.wen;
  assign rd_op     = i_cpu_req.ren & ~i_cpu_req.wen;  // write wins if both
  assign cacheable = (i_cpu_req.addr < `NONCACHE_START_ADDR);  // MMIO window bypass

  // array and request are both stable from lookup to resp, so hit holds too
  assign hit    = valid_q[idx] & (tag_arr[idx] == tag);
  assign rd_hit = rd_op & cacheable & hit;

  assign start_clear = i_clear | clear_pend;
  assign last_line   = (clr_idx == IDX_W'(LINES - 1));

  // memory side finishes when its busy falls with our request up
  assign mem_done  = (state_q == ST_MEM) & ~i_mem_rsp.busy;
  assign fill      = mem_done & rd_op & cacheable;         // read miss allocates
  assign wr_update = mem_done & wr_op & cacheable & hit;   // no write allocate

  assign o_clear_done = (state_q == ST_CLEAR) & last_line;

  always_comb begin
    state_n = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_clear) begin
          state_n = ST_CLEAR;  // clear first, request keeps waiting
        end else if (req_on) begin
          state_n = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (!req_on || rd_hit) begin
          state_n = ST_IDLE;   // hit answered this cycle
        end else begin
          state_n = ST_MEM;    // miss, write or MMIO
        end
      end
      ST_MEM: begin
        if (mem_done) begin
          state_n = ST_RESP;
        end
      end
      ST_RESP: begin
        state_n = ST_IDLE;
      end
      ST_CLEAR: begin
        if (last_line) begin
          state_n = ST_IDLE;
        end
      end
      default: begin
        state_n = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (i_rst) begin
      state_q    <= ST_IDLE;
      clr_idx    <= '0;
      clear_pend <= 1'b0;
    end else begin
      state_q <= state_n;
      if (state_q == ST_CLEAR) begin
        clr_idx <= clr_idx + 1'b1;  // wraps back to 0 after the last line
      end
      if (state_q == ST_IDLE) begin
        clear_pend <= 1'b0;         // idle always takes a pending clear
      end else if (i_clear) begin
        clear_pend <= 1'b1;
      end
    end
  end

  // valid bits, cleared one index at a time
  always_ff @(posedge CLK) begin
    if (i_rst) begin
      valid_q <= '0;
    end else if (state_q == ST_CLEAR) begin
      valid_q[clr_idx] <= 1'b0;
    end else if (fill) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge CLK) begin
    if (fill) begin
      data_arr[idx] <= i_mem_rsp.rdata;
      tag_arr[idx]  <= tag;
    end else if (wr_update) begin
      data_arr[idx] <= i_cpu_req.wdata;  // keep the hit line coherent
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_done) begin
      rdata_q <= i_mem_rsp.rdata;
    end
  end

  // cpu response
  always_comb begin
    o_cpu_rsp.rdata = data_arr[idx];  // hit data in lookup
    o_cpu_rsp.busy  = req_on;         // idle and clear hold the cpu off
    case (state_q)
      ST_LOOKUP: begin
        o_cpu_rsp.busy = req_on & ~rd_hit;
      end
      ST_MEM: begin
        o_cpu_rsp.busy = 1'b1;
      end
      ST_RESP: begin
        o_cpu_rsp.rdata = rdata_q;
        o_cpu_rsp.busy  = 1'b0;         // completing cycle
      end
      default: begin
        o_cpu_rsp.busy = req_on;
      end
    endcase
  end

  // memory request, the held cpu request with strobes only in ST_MEM
  always_comb begin
    o_mem_req = i_cpu_req;
    if (state_q != ST_MEM) begin
      o_mem_req.ren = 1'b0;
      o_mem_req.wen = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
// bus request and response types, referenced by scoped name from every cache module
`include "cache_defines.svh"
`default_nettype none

package cache_pkg;

  // one request on a cpu, cache or memory link
  // ren or wen stays up, with addr and wdata stable, until busy drops
  typedef struct packed {
    logic [`DATA_W-1:0] addr;   // byte address, low two bits ignored
    logic [`DATA_W-1:0] wdata;  // store data, only meaningful with wen
    logic               ren;    // read strobe
    logic               wen;    // write strobe
  } bus_req_t;  // 66 bits

  // the answer coming back up the same link
  // rdata counts only in the cycle where a request sees busy low
  typedef struct packed {
    logic [`DATA_W-1:0] rdata;  // load data
    logic               busy;   // request pending, hold it
  } bus_rsp_t;  // 33 bits

endpackage

`default_nettype wire

//--- hdl/cache_defines.svh
// shared width, size and latency macros, included by the cache RTL and the testbench
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// word and address width of every bus link
`define DATA_W 32

// default line count of one L1
// power of two only, the index is a plain slice of the word address
`define L1_LINES 16

// start of the memory-mapped I/O window
// everything from here up goes straight to memory
`define NONCACHE_START_ADDR 32'h8000_0000

// busy cycles per access in the testbench memory model
// the RTL never waits on a fixed count, it follows busy
`define MEM_LATENCY 3

`endif
